// File: logic/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath widths
`define CPU_DATA_W      8
`define CPU_REG_COUNT   16
`define CPU_REG_ADDR_W  4

// Instruction word
`define CPU_OPCODE_W    5
`define CPU_INST_W      25

// External ports
`define CPU_PORT_COUNT  4
`define CPU_PORT_SEL_W  2

`define CPU_QUEUE_DEPTH 4  // Queue slots, also the sender's credits after reset

`endif

// File: logic/cpuPkg.sv
`include "cpu_params.svh"

package cpuPkg;

    // Opcodes as encoded in the instruction word
    typedef enum logic [`CPU_OPCODE_W-1:0] {
        OP_ADD   = 5'b00000,
        OP_AND   = 5'b00001,
        OP_OR    = 5'b00010,
        OP_EXORI = 5'b00111,
        OP_INP   = 5'b01000,  // Input port to register
        OP_OUTP  = 5'b01001,  // Register to output port
        OP_MOVI  = 5'b01010,
        OP_SUB   = 5'b11000,
        OP_SHR   = 5'b11001   // Logical shift right
    } opcodeE;

    // Four phases per instruction
    typedef enum logic [1:0] {
        PH_T0,  // Fetch from queue
        PH_T1,  // Operand read
        PH_T2,  // Execute or port access
        PH_T3   // Write back
    } phaseE;

    // Register form, three register fields
    typedef struct packed {
        opcodeE                      opcode;
        logic [`CPU_REG_ADDR_W-1:0]  dest;
        logic [`CPU_REG_ADDR_W-1:0]  src1;
        logic [`CPU_REG_ADDR_W-1:0]  src2;
        logic [`CPU_INST_W-`CPU_OPCODE_W-3*`CPU_REG_ADDR_W-1:0] spare;
    } regFormS;

    // Immediate form, imm sits over src2 and the top of the spare bits
    typedef struct packed {
        opcodeE                      opcode;
        logic [`CPU_REG_ADDR_W-1:0]  dest;
        logic [`CPU_REG_ADDR_W-1:0]  src1;
        logic [`CPU_DATA_W-1:0]      imm;
        logic [`CPU_INST_W-`CPU_OPCODE_W-2*`CPU_REG_ADDR_W-`CPU_DATA_W-1:0] spare;
    } immFormS;

    typedef union packed {
        regFormS regForm;
        immFormS immForm;
    } instWordU;

endpackage

// File: logic/cpuIfs.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

////////////////////////////////////////
// Register file access
////////////////////////////////////////
interface regIf;
    logic                       readEn;
    logic [`CPU_REG_ADDR_W-1:0] src1;
    logic [`CPU_REG_ADDR_W-1:0] src2;
    logic                       writeEn;
    logic [`CPU_REG_ADDR_W-1:0] dest;
    logic [`CPU_DATA_W-1:0]     writeData;
    logic [`CPU_DATA_W-1:0]     rdata1;  // Registered read data
    logic [`CPU_DATA_W-1:0]     rdata2;

    modport ctrl (output readEn, src1, src2, writeEn, dest, writeData,
                  input rdata1, rdata2);
    modport unit (input readEn, src1, src2, writeEn, dest, writeData,
                  output rdata1, rdata2);
endinterface

////////////////////////////////////////
// ALU operands and result
////////////////////////////////////////
interface aluIf;
    cpuPkg::opcodeE         opcode;
    logic [`CPU_DATA_W-1:0] operand1;
    logic [`CPU_DATA_W-1:0] operand2;
    logic [`CPU_DATA_W-1:0] imm;
    logic                   save;    // Load result register
    logic [`CPU_DATA_W-1:0] result;

    modport ctrl (output opcode, operand1, operand2, imm, save, input result);
    modport unit (input opcode, operand1, operand2, imm, save, output result);
endinterface

// Port access
interface ioIf;
    logic                       inRead;
    logic                       outWrite;
    logic [`CPU_PORT_SEL_W-1:0] portSel;
    logic [`CPU_DATA_W-1:0]     outData;
    logic [`CPU_DATA_W-1:0]     inData;

    modport ctrl (output inRead, outWrite, portSel, outData, input inData);
    modport unit (input inRead, outWrite, portSel, outData, output inData);
endinterface

// File: logic/instQueue.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module instQueue #(
    parameter int depth = `CPU_QUEUE_DEPTH
) (
    input  logic              clk,
    input  logic              Reset,
    input  logic              instValid,  // Push, one word per cycle
    input  cpuPkg::instWordU  instWord,
    input  logic              pop,
    output logic              headValid,
    output cpuPkg::instWordU  headWord,
    output logic              instCredit  // One pulse per freed slot
);

    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    cpuPkg::instWordU mem [depth];  // Word storage
    logic [ptrW-1:0]  wrPtr;
    logic [ptrW-1:0]  rdPtr;
    logic [cntW-1:0]  count;        // Occupancy

    // Circular increment
    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        if (ptr == ptrW'(depth - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (instValid)
            mem[wrPtr] <= instWord;
    end

    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            instCredit <= 1'b0;
        end else begin
            if (instValid) wrPtr <= nextPtr(wrPtr);
            if (pop)       rdPtr <= nextPtr(rdPtr);
            case ({instValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or both
            endcase
            instCredit <= pop;  // Credit back one cycle after the pop
        end
    end

    assign headValid = (count != '0);
    assign headWord  = mem[rdPtr];

    // Sender must hold a credit for every word
    assert property (@(posedge clk) disable iff (Reset) instValid |-> count != cntW'(depth))
        else $error("instQueue push while full");
    assert property (@(posedge clk) disable iff (Reset) pop |-> headValid)
        else $error("instQueue pop while empty");

endmodule

// File: logic/sequencer.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module sequencer (
    input  logic             clk,
    input  logic             Reset,
    input  logic             headValid,
    input  cpuPkg::instWordU headWord,
    output logic             pop,
    regIf.ctrl               regBus,
    aluIf.ctrl               aluBus,
    ioIf.ctrl                ioBus
);

    cpuPkg::phaseE    phase;
    cpuPkg::instWordU instReg;  // Instruction in flight
    logic             useRegs;  // Reads register operands in T1
    logic             useAlu;   // Saves in T2, writes back in T3
    logic             isIn;
    logic             isOut;

    ////////////////////////////////////////
    // Timing generator
    ////////////////////////////////////////
    assign pop = (phase == cpuPkg::PH_T0) && headValid;  // Fetch only from T0

    always_ff @(posedge clk or posedge Reset) begin
        if (Reset)
            phase <= cpuPkg::PH_T0;
        else begin
            case (phase)
                cpuPkg::PH_T0: if (headValid) phase <= cpuPkg::PH_T1;  // Else idle
                cpuPkg::PH_T1: phase <= cpuPkg::PH_T2;
                cpuPkg::PH_T2: phase <= cpuPkg::PH_T3;
                default:       phase <= cpuPkg::PH_T0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop)
            instReg <= headWord;
    end

    ////////////////////////////////////////
    // Control table
    ////////////////////////////////////////
    always_comb begin
        useRegs = 1'b0;
        useAlu  = 1'b0;
        isIn    = 1'b0;
        isOut   = 1'b0;
        case (instReg.regForm.opcode)
            cpuPkg::OP_ADD, cpuPkg::OP_SUB, cpuPkg::OP_AND,
            cpuPkg::OP_OR, cpuPkg::OP_SHR, cpuPkg::OP_EXORI: begin
                useRegs = 1'b1;
                useAlu  = 1'b1;
            end
            cpuPkg::OP_MOVI: useAlu = 1'b1;   // Imm only, no read
            cpuPkg::OP_INP:  isIn = 1'b1;
            cpuPkg::OP_OUTP: begin
                useRegs = 1'b1;
                isOut   = 1'b1;
            end
            default: ;  // Unknown opcode runs as a no-op
        endcase
    end

    // Strobes per phase
    assign regBus.readEn  = (phase == cpuPkg::PH_T1) && useRegs;
    assign ioBus.inRead   = (phase == cpuPkg::PH_T1) && isIn;
    assign aluBus.save    = (phase == cpuPkg::PH_T2) && useAlu;
    assign ioBus.outWrite = (phase == cpuPkg::PH_T2) && isOut;
    assign regBus.writeEn = ((phase == cpuPkg::PH_T2) && isIn)
                          || ((phase == cpuPkg::PH_T3) && useAlu);

    // Datapath routing
    assign regBus.src1      = instReg.regForm.src1;
    assign regBus.src2      = instReg.regForm.src2;
    assign regBus.dest      = instReg.regForm.dest;
    assign regBus.writeData = isIn ? ioBus.inData : aluBus.result;
    assign aluBus.opcode    = instReg.regForm.opcode;
    assign aluBus.operand1  = regBus.rdata1;
    assign aluBus.operand2  = regBus.rdata2;
    assign aluBus.imm       = instReg.immForm.imm;   // Same bits as src2 and spare top
    assign ioBus.portSel    = instReg.immForm.imm[`CPU_PORT_SEL_W-1:0];
    assign ioBus.outData    = regBus.rdata1;

    // Queue keeps its head word until the pop takes it
    assert property (@(posedge clk) disable iff (Reset) headValid && !pop |=> headValid)
        else $error("sequencer lost a head word before popping it");

endmodule

// File: logic/regFile.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module regFile (
    input  logic clk,
    input  logic Reset,
    regIf.unit   regBus
);

    logic [`CPU_DATA_W-1:0]    regs [`CPU_REG_COUNT];
    logic [`CPU_REG_COUNT-1:0] wrDec;  // One-hot write select

    assign wrDec = regBus.writeEn ? (`CPU_REG_COUNT'(1) << regBus.dest) : '0;

    // Sixteen loadable registers
    for (genvar i = 0; i < `CPU_REG_COUNT; i++) begin : gReg
        always_ff @(posedge clk or posedge Reset) begin
            if (Reset)
                regs[i] <= '0;
            else if (wrDec[i])
                regs[i] <= regBus.writeData;
        end
    end

    // Read muxes into the output registers
    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            regBus.rdata1 <= '0;
            regBus.rdata2 <= '0;
        end else if (regBus.readEn) begin
            regBus.rdata1 <= regs[regBus.src1];
            regBus.rdata2 <= regs[regBus.src2];
        end
    end

    // Read and write fall in different phases of the sequencer
    assert property (@(posedge clk) disable iff (Reset) !(regBus.writeEn && regBus.readEn))
        else $error("regFile read and write in the same cycle");

endmodule

// File: logic/alu.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module alu (
    input  logic clk,
    input  logic Reset,
    aluIf.unit   aluBus
);

    logic [`CPU_DATA_W-1:0] aluOut;  // Combinational result

    always_comb begin
        case (aluBus.opcode)
            cpuPkg::OP_ADD:   aluOut = aluBus.operand1 + aluBus.operand2;  // Mod 256
            cpuPkg::OP_SUB:   aluOut = aluBus.operand1 - aluBus.operand2;  // Wraps on borrow
            cpuPkg::OP_AND:   aluOut = aluBus.operand1 & aluBus.operand2;
            cpuPkg::OP_OR:    aluOut = aluBus.operand1 | aluBus.operand2;
            cpuPkg::OP_EXORI: aluOut = aluBus.operand1 ^ aluBus.imm;
            cpuPkg::OP_SHR: begin
                // Whole word shifted out at 8 or more
                if (aluBus.operand2 >= `CPU_DATA_W)
                    aluOut = '0;
                else
                    aluOut = aluBus.operand1 >> aluBus.operand2;
            end
            cpuPkg::OP_MOVI:  aluOut = aluBus.imm;
            default:          aluOut = '0;
        endcase
    end

    // Result register
    always_ff @(posedge clk or posedge Reset) begin
        if (Reset)
            aluBus.result <= '0;
        else if (aluBus.save)
            aluBus.result <= aluOut;  // Held for write back in T3
    end

endmodule

// File: logic/ioPorts.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module ioPorts (
    input  logic                   clk,
    input  logic                   Reset,
    input  logic [`CPU_DATA_W-1:0] inPort0,
    input  logic [`CPU_DATA_W-1:0] inPort1,
    input  logic [`CPU_DATA_W-1:0] inPort2,
    input  logic [`CPU_DATA_W-1:0] inPort3,
    output logic [`CPU_DATA_W-1:0] outPort0,
    output logic [`CPU_DATA_W-1:0] outPort1,
    output logic [`CPU_DATA_W-1:0] outPort2,
    output logic [`CPU_DATA_W-1:0] outPort3,
    ioIf.unit                      ioBus
);

    logic [`CPU_DATA_W-1:0] inSel [`CPU_PORT_COUNT];
    logic [`CPU_DATA_W-1:0] outRegs [`CPU_PORT_COUNT];  // Output port registers

    assign inSel = '{inPort0, inPort1, inPort2, inPort3};

    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            ioBus.inData <= '0;
            outRegs      <= '{default: '0};
        end else begin
            if (ioBus.inRead)   ioBus.inData <= inSel[ioBus.portSel];  // Sampled in T1
            if (ioBus.outWrite) outRegs[ioBus.portSel] <= ioBus.outData;
        end
    end

    assign outPort0 = outRegs[0];
    assign outPort1 = outRegs[1];
    assign outPort2 = outRegs[2];
    assign outPort3 = outRegs[3];

endmodule

// File: logic/miniCpu.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module miniCpu (
    input  logic                   clk,
    input  logic                   Reset,
    input  logic                   instValid,
    input  logic [`CPU_INST_W-1:0] instWord,
    input  logic [`CPU_DATA_W-1:0] inPort0,
    input  logic [`CPU_DATA_W-1:0] inPort1,
    input  logic [`CPU_DATA_W-1:0] inPort2,
    input  logic [`CPU_DATA_W-1:0] inPort3,
    output logic                   instCredit,
    output logic [`CPU_DATA_W-1:0] outPort0,
    output logic [`CPU_DATA_W-1:0] outPort1,
    output logic [`CPU_DATA_W-1:0] outPort2,
    output logic [`CPU_DATA_W-1:0] outPort3
);

    logic             headValid;
    cpuPkg::instWordU headWord;
    logic             pop;

    regIf regBus ();
    aluIf aluBus ();
    ioIf  ioBus ();

    ////////////////////////////////////////
    // Front end
    ////////////////////////////////////////
    instQueue #(.depth(`CPU_QUEUE_DEPTH)) queue (
        .clk, .Reset, .instValid,
        .instWord   (cpuPkg::instWordU'(instWord)),
        .pop, .headValid, .headWord, .instCredit
    );

    sequencer seq (
        .clk, .Reset, .headValid, .headWord, .pop,
        .regBus (regBus.ctrl),
        .aluBus (aluBus.ctrl),
        .ioBus  (ioBus.ctrl)
    );

    ////////////////////////////////////////
    // Datapath units
    ////////////////////////////////////////
    regFile regs (.clk, .Reset, .regBus (regBus.unit));

    alu aluUnit (.clk, .Reset, .aluBus (aluBus.unit));

    ioPorts io (
        .clk, .Reset,
        .inPort0, .inPort1, .inPort2, .inPort3,
        .outPort0, .outPort1, .outPort2, .outPort3,
        .ioBus (ioBus.unit)
    );

endmodule

// File: verif/tbMiniCpu.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module tbMiniCpu;

    logic                   clk;
    logic                   Reset;
    logic                   instValid;
    logic [`CPU_INST_W-1:0] instWord;
    logic [`CPU_DATA_W-1:0] inPort0, inPort1, inPort2, inPort3;
    logic                   instCredit;
    logic [`CPU_DATA_W-1:0] outPort0, outPort1, outPort2, outPort3;

    logic [`CPU_DATA_W-1:0] outNow [`CPU_PORT_COUNT];
    logic [`CPU_DATA_W-1:0] portPrev [`CPU_PORT_COUNT];  // Port values one edge back
    logic [`CPU_DATA_W-1:0] inVals [`CPU_PORT_COUNT];
    logic [`CPU_DATA_W-1:0] regModel [`CPU_REG_COUNT];   // Reference registers
    logic [`CPU_DATA_W-1:0] portModel [`CPU_PORT_COUNT];
    logic [`CPU_DATA_W-1:0] expQ [`CPU_PORT_COUNT][$];  // Pending port changes
    logic [`CPU_DATA_W-1:0] headVal [`CPU_PORT_COUNT];
    logic [`CPU_PORT_COUNT-1:0] headAvail;
    int                     credits;
    logic                   started;  // First word sent
    cpuPkg::opcodeE         legalOps [9] = '{cpuPkg::OP_ADD, cpuPkg::OP_SUB, cpuPkg::OP_AND,
        cpuPkg::OP_OR, cpuPkg::OP_EXORI, cpuPkg::OP_SHR, cpuPkg::OP_MOVI, cpuPkg::OP_INP,
        cpuPkg::OP_OUTP};

    miniCpu DUT (.*);

    assign outNow = '{outPort0, outPort1, outPort2, outPort3};

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // Head of each expected queue, as plain signals for the checks
    task automatic refreshHeads();
        for (int p = 0; p < `CPU_PORT_COUNT; p++) begin
            headAvail[p[1:0]] = (expQ[p[1:0]].size() != 0);
            headVal[p[1:0]]   = '0;
            if (headAvail[p[1:0]])
                headVal[p[1:0]] = expQ[p[1:0]][0];
        end
    endtask

    function automatic cpuPkg::instWordU makeImmWord(input cpuPkg::opcodeE op,
            input logic [3:0] dest, input logic [3:0] src1, input logic [7:0] imm);
        cpuPkg::instWordU w;
        w = '0;
        w.immForm.opcode = op;
        w.immForm.dest   = dest;
        w.immForm.src1   = src1;
        w.immForm.imm    = imm;
        return w;
    endfunction

    function automatic cpuPkg::instWordU makeRegWord(input cpuPkg::opcodeE op,
            input logic [3:0] dest, input logic [3:0] src1, input logic [3:0] src2);
        cpuPkg::instWordU w;
        w = '0;
        w.regForm.opcode = op;
        w.regForm.dest   = dest;
        w.regForm.src1   = src1;
        w.regForm.src2   = src2;
        return w;
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    task automatic applyModel(input cpuPkg::instWordU w);
        logic [7:0] a;
        logic [7:0] b;
        logic [1:0] p;
        a = regModel[w.regForm.src1];
        b = regModel[w.regForm.src2];
        p = w.immForm.imm[1:0];  // Port select for IN and OUT
        case (w.regForm.opcode)
            cpuPkg::OP_ADD:   regModel[w.regForm.dest] = a + b;
            cpuPkg::OP_SUB:   regModel[w.regForm.dest] = a - b;
            cpuPkg::OP_AND:   regModel[w.regForm.dest] = a & b;
            cpuPkg::OP_OR:    regModel[w.regForm.dest] = a | b;
            cpuPkg::OP_EXORI: regModel[w.regForm.dest] = a ^ w.immForm.imm;
            cpuPkg::OP_SHR:   regModel[w.regForm.dest] = (b > 8'd7) ? 8'h00 : (a >> b);
            cpuPkg::OP_MOVI:  regModel[w.regForm.dest] = w.immForm.imm;
            cpuPkg::OP_INP:   regModel[w.regForm.dest] = inVals[p];
            cpuPkg::OP_OUTP: begin
                if (a != portModel[p])
                    expQ[p].push_back(a);  // Only a real change is visible
                portModel[p] = a;
            end
            default: ;
        endcase
        refreshHeads();
    endtask

    // Credit back from the queue
    always @(posedge clk) begin
        if (!Reset && instCredit)
            credits++;
    end

    // Retire a change seen on the last edge
    always @(posedge clk) begin
        if (!Reset) begin
            for (int p = 0; p < `CPU_PORT_COUNT; p++) begin
                if (outNow[p[1:0]] != portPrev[p[1:0]] && expQ[p[1:0]].size() != 0)
                    void'(expQ[p[1:0]].pop_front());
            end
            refreshHeads();
        end
        portPrev <= outNow;
    end

    task automatic sendInst(input cpuPkg::instWordU w);
        int waited;
        waited = 0;
        while (credits == 0 && waited < 100) begin  // Stall on zero credits
            @(posedge clk);
            #10;
            waited++;
        end
        if (credits == 0)
            abortRun("sender timed out waiting for a queue credit");
        instValid = 1'b1;
        instWord  = w;
        credits--;
        started   = 1'b1;
        applyModel(w);
        @(posedge clk);
        #10;
        instValid = 1'b0;
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    assert property (@(negedge clk) disable iff (Reset) !started |-> !instCredit)
        else abortRun($sformatf("error at %0t: instCredit expected 0 got %b", $time, instCredit));
    assert property (@(negedge clk) disable iff (Reset)
            !started |-> {outPort3, outPort2, outPort1, outPort0} == '0)
        else abortRun($sformatf("error at %0t: outPorts expected 00000000 got %h", $time,
            {outPort3, outPort2, outPort1, outPort0}));
    assert property (@(negedge clk) disable iff (Reset)
            credits >= 0 && credits <= `CPU_QUEUE_DEPTH)
        else abortRun($sformatf("error at %0t: credits expected 0..%0d got %0d", $time,
            `CPU_QUEUE_DEPTH, credits));

    for (genvar p = 0; p < `CPU_PORT_COUNT; p++) begin : gPortChk
        assert property (@(negedge clk) disable iff (Reset)
                outNow[p] != portPrev[p] |-> headAvail[p])
            else abortRun($sformatf("outPort%0d changed at %0t with no OUT pending", p, $time));
        assert property (@(negedge clk) disable iff (Reset)
                outNow[p] != portPrev[p] && headAvail[p] |-> outNow[p] == headVal[p])
            else abortRun($sformatf("error at %0t: outPort%0d expected %h got %h", $time, p,
                headVal[p], outNow[p]));
    end

    initial begin
        int unusedSeed;
        int waited;
        logic [3:0] opIdx;
        unusedSeed = $urandom(85232);
        Reset      = 1'b1;
        instValid  = 1'b0;
        instWord   = '0;
        credits    = `CPU_QUEUE_DEPTH;
        started    = 1'b0;
        regModel   = '{default: '0};
        portModel  = '{default: '0};
        inVals     = '{8'($urandom), 8'($urandom), 8'($urandom), 8'($urandom)};
        {inPort0, inPort1, inPort2, inPort3} = {inVals[0], inVals[1], inVals[2], inVals[3]};
        refreshHeads();
        repeat (5) @(posedge clk);
        #10;
        Reset = 1'b0;
        repeat (3) @(posedge clk);  // Idle, nothing sent yet
        #10;

        // Directed ALU sequence
        sendInst(makeImmWord(cpuPkg::OP_MOVI, 4'd1, 4'd0, 8'hF0));
        sendInst(makeImmWord(cpuPkg::OP_MOVI, 4'd2, 4'd0, 8'h25));
        sendInst(makeRegWord(cpuPkg::OP_ADD, 4'd3, 4'd1, 4'd2));  // Carry wraps
        sendInst(makeImmWord(cpuPkg::OP_OUTP, 4'd0, 4'd3, 8'd0));
        sendInst(makeRegWord(cpuPkg::OP_SUB, 4'd4, 4'd2, 4'd1));  // Borrow
        sendInst(makeImmWord(cpuPkg::OP_OUTP, 4'd0, 4'd4, 8'd1));
        sendInst(makeRegWord(cpuPkg::OP_AND, 4'd5, 4'd1, 4'd2));
        sendInst(makeImmWord(cpuPkg::OP_OUTP, 4'd0, 4'd5, 8'd2));
        sendInst(makeRegWord(cpuPkg::OP_OR, 4'd6, 4'd1, 4'd2));
        sendInst(makeImmWord(cpuPkg::OP_OUTP, 4'd0, 4'd6, 8'd3));
        sendInst(makeImmWord(cpuPkg::OP_EXORI, 4'd7, 4'd1, 8'h5A));
        sendInst(makeImmWord(cpuPkg::OP_OUTP, 4'd0, 4'd7, 8'd0));
        sendInst(makeImmWord(cpuPkg::OP_MOVI, 4'd8, 4'd0, 8'd3));
        sendInst(makeRegWord(cpuPkg::OP_SHR, 4'd9, 4'd1, 4'd8));
        sendInst(makeImmWord(cpuPkg::OP_OUTP, 4'd0, 4'd9, 8'd1));
        sendInst(makeImmWord(cpuPkg::OP_MOVI, 4'd10, 4'd0, 8'd9));
        sendInst(makeRegWord(cpuPkg::OP_SHR, 4'd11, 4'd1, 4'd10));  // Shift of 9 gives 0
        sendInst(makeImmWord(cpuPkg::OP_OUTP, 4'd0, 4'd11, 8'd2));

        // Each input port out again
        for (int p = 0; p < `CPU_PORT_COUNT; p++) begin
            sendInst(makeImmWord(cpuPkg::OP_INP, 4'(12 + p), 4'd0, 8'(p)));
            sendInst(makeImmWord(cpuPkg::OP_OUTP, 4'd0, 4'(12 + p), 8'(p)));
        end

        // Random burst
        for (int i = 0; i < 200; i++) begin
            opIdx = 4'($urandom_range(8, 0));
            sendInst(makeImmWord(legalOps[opIdx], 4'($urandom), 4'($urandom), 8'($urandom)));
        end

        waited = 0;
        while (credits != `CPU_QUEUE_DEPTH && waited < 200) begin
            @(posedge clk);
            #10;
            waited++;
        end
        if (credits != `CPU_QUEUE_DEPTH)
            abortRun("queue credits did not all return after the stream drained");
        repeat (6) @(posedge clk);  // Last instruction finishes its phases
        #10;

        for (int p = 0; p < `CPU_PORT_COUNT; p++) begin
            assert (outNow[p[1:0]] == portModel[p[1:0]])
                else abortRun($sformatf("error at %0t: outPort%0d expected %h got %h", $time,
                    p, portModel[p[1:0]], outNow[p[1:0]]));
            assert (expQ[p[1:0]].size() == 0)
                else abortRun($sformatf("outPort%0d never showed %0d expected values", p,
                    expQ[p[1:0]].size()));
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+logic
logic/cpuPkg.sv
logic/cpuIfs.sv
logic/instQueue.sv
logic/sequencer.sv
logic/regFile.sv
logic/alu.sv
logic/ioPorts.sv
logic/miniCpu.sv
verif/tbMiniCpu.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the miniCpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbMiniCpu -f tb.f -o simMiniCpu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/simMiniCpu 2>&1)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
